/* tlast_pkg.sv */
`default_nettype none

package tlast_pkg;

   // link and user payload width, fixed by the two-half checksum fold
   typedef logic [63:0] word_t;

   // xor of upper and lower halves, accumulated over a packet
   typedef logic [31:0] csum_t;

   // statistics counter width
   typedef logic [31:0] count_t;

   // user side beat, data plus the end-of-packet flag
   typedef struct packed {
      word_t data;
      logic  last;
   } beat_t;

   // reserved in-band escape value
   localparam word_t ESC_WORD = 64'hDEADBEEFFEEDCAFE;

   // transmit sequencer states
   typedef enum logic [1:0] {
      ST_IDLE   = 2'd0, // pass through, watch for last or escape data
      ST_LAST   = 2'd1, // marker with last bit and checksum
      ST_ESC    = 2'd2, // zero marker for escape-valued data
      ST_FINISH = 2'd3  // pass the held beat itself
   } embed_state_e;

   // transmit output mux select
   typedef enum logic [1:0] {
      SEL_PASS   = 2'd0,
      SEL_ZERO   = 2'd1,
      SEL_MARK   = 2'd2,
      SEL_ESCAPE = 2'd3
   } embed_sel_e;

   // receive sequencer states
   typedef enum logic [1:0] {
      ST_DATA = 2'd0, // plain data, look for escape
      ST_MARK = 2'd1, // swallow marker word
      ST_HELD = 2'd2  // next word is the escaped beat
   } extract_state_e;

endpackage

`default_nettype wire

/* frame_checksum.sv */
`default_nettype none

module frame_checksum (
   input  wire logic             clk,
   input  wire logic             i_rst,
   input  wire tlast_pkg::word_t i_word,
   input  wire logic             i_take, // word accepted this cycle
   input  wire logic             i_last, // accepted word ends the packet
   output tlast_pkg::csum_t      o_csum
);

   import tlast_pkg::*;

   csum_t acc_q; // running fold of the packet so far
   csum_t fold;  // contribution of the current word

   assign fold = i_word[63:32] ^ i_word[31:0];

   always_ff @(posedge clk) begin
      if (i_rst) begin
         acc_q <= '0;
      end else if (i_take) begin
         if (i_last) begin
            acc_q <= '0; // last word is not covered, start next packet
         end else begin
            acc_q <= acc_q ^ fold;
         end
      end
   end

   // value before the last beat is taken
   assign o_csum = acc_q;

endmodule

`default_nettype wire

/* tlast_embed.sv */
`default_nettype none

module tlast_embed #(
   parameter bit CHECKSUM_EN = 1'b1
) (
   input  wire logic             clk,
   input  wire logic             i_rst,
   // user side in
   input  wire tlast_pkg::beat_t i_beat,
   input  wire logic             i_valid,
   output logic                  o_ready,
   // link side out
   output tlast_pkg::word_t      o_data,
   output logic                  o_valid,
   input  wire logic             i_ready
);

   import tlast_pkg::*;

   embed_state_e state_q;
   embed_state_e state_d;
   embed_sel_e   sel;
   csum_t        tx_csum;
   csum_t        mark_hi;  // upper half of the last marker
   logic         in_xfer;  // user beat accepted

   assign in_xfer = i_valid && o_ready;

   // checksum over accepted user beats, escaped data included
   frame_checksum u_tx_csum (
      .clk    (clk),
      .i_rst  (i_rst),
      .i_word (i_beat.data),
      .i_take (in_xfer),
      .i_last (i_beat.last),
      .o_csum (tx_csum)
   );

   assign mark_hi = CHECKSUM_EN ? tx_csum : '0;

   // sequence only moves on an accepted link word
   always_ff @(posedge clk) begin
      if (i_rst) begin
         state_q <= ST_IDLE;
      end else if (i_ready) begin
         state_q <= state_d;
      end
   end

   always_comb begin
      state_d = state_q;
      sel     = SEL_PASS;
      case (state_q)
         ST_IDLE: begin
            if (i_valid && i_beat.last) begin
               state_d = ST_LAST; // needs escape + marker first
               sel     = SEL_ESCAPE;
            end else if (i_valid && (i_beat.data == ESC_WORD)) begin
               state_d = ST_ESC;  // data collides with escape
               sel     = SEL_ESCAPE;
            end
         end
         ST_LAST: begin
            state_d = ST_FINISH;
            sel     = SEL_MARK;
         end
         ST_ESC: begin
            state_d = ST_FINISH;
            sel     = SEL_ZERO;
         end
         ST_FINISH: begin
            sel = SEL_PASS; // the beat itself goes out now
            if (i_valid) begin
               state_d = ST_IDLE;
            end
         end
         default: begin
            state_d = ST_IDLE;
         end
      endcase
   end

   // output mux
   always_comb begin
      case (sel)
         SEL_ZERO:   o_data = '0;
         SEL_MARK:   o_data = {mark_hi, 32'h1};
         SEL_ESCAPE: o_data = ESC_WORD;
         default:    o_data = i_beat.data;
      endcase
   end

   // inserted words are always valid and hold off the user side
   assign o_valid = (sel == SEL_PASS) ? i_valid : 1'b1;
   assign o_ready = (sel == SEL_PASS) ? i_ready : 1'b0;

endmodule

`default_nettype wire

/* link_fifo.sv */
`default_nettype none

module link_fifo #(
   parameter int FIFO_DEPTH = 4 // power of two, at least 2
) (
   input  wire logic             clk,
   input  wire logic             i_rst,
   // write side
   input  wire tlast_pkg::word_t i_data,
   input  wire logic             i_valid,
   output logic                  o_ready,
   // read side
   output tlast_pkg::word_t      o_data,
   output logic                  o_valid,
   input  wire logic             i_ready
);

   import tlast_pkg::*;

   localparam int PTR_W = $clog2(FIFO_DEPTH);

   typedef logic [PTR_W-1:0] ptr_t;
   typedef logic [PTR_W:0]   occ_t; // holds 0..FIFO_DEPTH

   word_t mem [FIFO_DEPTH];
   ptr_t  wr_ptr_q;
   ptr_t  rd_ptr_q;
   occ_t  count_q;
   logic  wr_en;
   logic  rd_en;

   assign o_ready = (count_q != occ_t'(FIFO_DEPTH)); // low only when full
   assign o_valid = (count_q != '0);
   assign o_data  = mem[rd_ptr_q];                  // head word

   assign wr_en = i_valid && o_ready;
   assign rd_en = o_valid && i_ready;

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_ptr_q] <= i_data;
      end
   end

   // pointers wrap on their own, depth is a power of two
   always_ff @(posedge clk) begin
      if (i_rst) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (wr_en) wr_ptr_q <= wr_ptr_q + 1'b1;
         if (rd_en) rd_ptr_q <= rd_ptr_q + 1'b1;
         if (wr_en && !rd_en) begin
            count_q <= count_q + 1'b1;
         end else if (rd_en && !wr_en) begin
            count_q <= count_q - 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

/* tlast_extract.sv */
`default_nettype none

module tlast_extract #(
   parameter bit CHECKSUM_EN = 1'b1
) (
   input  wire logic             clk,
   input  wire logic             i_rst,
   // link side in from the fifo
   input  wire tlast_pkg::word_t i_data,
   input  wire logic             i_valid,
   output logic                  o_ready,
   // user side out
   output tlast_pkg::beat_t      o_beat,
   output logic                  o_valid,
   input  wire logic             i_ready,
   output logic                  o_csum_err // with the last beat transfer
);

   import tlast_pkg::*;

   extract_state_e state_q;
   extract_state_e state_d;
   logic           held_last_q; // marker bit 0
   csum_t          held_csum_q; // marker upper half
   csum_t          rx_csum;
   logic           out_xfer;

   assign out_xfer = o_valid && i_ready;

   always_ff @(posedge clk) begin
      if (i_rst) begin
         state_q     <= ST_DATA;
         held_last_q <= 1'b0;
      end else begin
         state_q <= state_d;
         if (state_q == ST_MARK && i_valid) begin
            held_last_q <= i_data[0];
         end
      end
   end

   // checksum field taken from the marker word
   always_ff @(posedge clk) begin
      if (state_q == ST_MARK && i_valid) begin
         held_csum_q <= i_data[63:32];
      end
   end

   always_comb begin
      state_d     = state_q;
      o_beat.data = i_data;
      o_beat.last = 1'b0;
      o_valid     = i_valid; // pass through by default
      o_ready     = i_ready;
      case (state_q)
         ST_DATA: begin
            if (i_data == ESC_WORD) begin
               o_valid = 1'b0; // swallow escape
               o_ready = 1'b1;
               if (i_valid) begin
                  state_d = ST_MARK;
               end
            end
         end
         ST_MARK: begin
            o_valid = 1'b0; // swallow marker
            o_ready = 1'b1;
            if (i_valid) begin
               state_d = ST_HELD;
            end
         end
         ST_HELD: begin
            o_beat.last = held_last_q;
            if (i_valid && i_ready) begin
               state_d = ST_DATA;
            end
         end
         default: begin
            state_d = ST_DATA;
         end
      endcase
   end

   // local fold over delivered beats
   frame_checksum u_rx_csum (
      .clk    (clk),
      .i_rst  (i_rst),
      .i_word (o_beat.data),
      .i_take (out_xfer),
      .i_last (o_beat.last),
      .o_csum (rx_csum)
   );

   // marker checksum vs what actually arrived
   assign o_csum_err = CHECKSUM_EN && out_xfer && o_beat.last
                       && (held_csum_q != rx_csum);

endmodule

`default_nettype wire

/* link_stats.sv */
`default_nettype none

module link_stats (
   input  wire logic        clk,
   input  wire logic        i_rst,
   input  wire logic        i_beat_done, // output handshake
   input  wire logic        i_last,
   input  wire logic        i_csum_err,
   output tlast_pkg::count_t o_pkt_count,
   output tlast_pkg::count_t o_err_count
);

   import tlast_pkg::*;

   localparam count_t CNT_MAX = '1;

   count_t pkt_q;
   count_t err_q;
   logic   pkt_done; // last beat delivered

   assign pkt_done = i_beat_done && i_last;

   always_ff @(posedge clk) begin
      if (i_rst) begin
         pkt_q <= '0;
         err_q <= '0;
      end else if (pkt_done) begin
         if (pkt_q != CNT_MAX) pkt_q <= pkt_q + 1'b1; // saturate
         if (i_csum_err && err_q != CNT_MAX) begin
            err_q <= err_q + 1'b1;
         end
      end
   end

   assign o_pkt_count = pkt_q;
   assign o_err_count = err_q;

endmodule

`default_nettype wire

/* tlast_link.sv */
`default_nettype none

module tlast_link #(
   parameter bit CHECKSUM_EN = 1'b1,
   parameter int FIFO_DEPTH  = 4
) (
   input  wire logic             clk,
   input  wire logic             i_rst,
   // user stream in
   input  wire tlast_pkg::beat_t i_s_beat,
   input  wire logic             i_s_valid,
   output logic                  o_s_ready,
   // link out
   output tlast_pkg::word_t      o_link_data,
   output logic                  o_link_valid,
   input  wire logic             i_link_ready,
   // link in
   input  wire tlast_pkg::word_t i_link_data,
   input  wire logic             i_link_valid,
   output logic                  o_link_ready,
   // user stream out
   output tlast_pkg::beat_t      o_m_beat,
   output logic                  o_m_valid,
   input  wire logic             i_m_ready,
   // stats
   output tlast_pkg::count_t     o_pkt_count,
   output tlast_pkg::count_t     o_err_count
);

   import tlast_pkg::*;

   word_t fifo_data;  // fifo head toward extractor
   logic  fifo_valid;
   logic  fifo_ready;
   logic  csum_err;
   logic  beat_done;  // user output handshake

   assign beat_done = o_m_valid && i_m_ready;

   tlast_embed #(.CHECKSUM_EN(CHECKSUM_EN)) u_embed (
      .clk(clk), .i_rst(i_rst),
      .i_beat(i_s_beat), .i_valid(i_s_valid), .o_ready(o_s_ready),
      .o_data(o_link_data), .o_valid(o_link_valid), .i_ready(i_link_ready)
   );

   link_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
      .clk(clk), .i_rst(i_rst),
      .i_data(i_link_data), .i_valid(i_link_valid), .o_ready(o_link_ready),
      .o_data(fifo_data), .o_valid(fifo_valid), .i_ready(fifo_ready)
   );

   tlast_extract #(.CHECKSUM_EN(CHECKSUM_EN)) u_extract (
      .clk(clk), .i_rst(i_rst),
      .i_data(fifo_data), .i_valid(fifo_valid), .o_ready(fifo_ready),
      .o_beat(o_m_beat), .o_valid(o_m_valid), .i_ready(i_m_ready),
      .o_csum_err(csum_err)
   );

   link_stats u_stats (
      .clk         (clk),
      .i_rst       (i_rst),
      .i_beat_done (beat_done),
      .i_last      (o_m_beat.last),
      .i_csum_err  (csum_err),
      .o_pkt_count (o_pkt_count),
      .o_err_count (o_err_count)
   );

endmodule

`default_nettype wire

/* tb_tlast_link.sv */
`default_nettype none

module tb_tlast_link;

   timeunit 1ns;
   timeprecision 1ps;

   import tlast_pkg::*;

   typedef word_t word_q_t[$];
   typedef beat_t beat_q_t[$];

   localparam bit          CHECKSUM_EN = 1'b1;
   localparam int          FIFO_DEPTH  = 4;
   localparam logic [31:0] SEED        = 32'h3629_a118;
   localparam int          DRAIN_LIMIT = 4000; // cycles allowed per drain

   logic   clk;
   logic   i_rst;
   beat_t  i_s_beat;
   logic   i_s_valid;
   logic   o_s_ready;
   word_t  o_link_data;
   logic   o_link_valid;
   logic   i_link_ready;
   word_t  i_link_data;
   logic   i_link_valid;
   logic   o_link_ready;
   beat_t  o_m_beat;
   logic   o_m_valid;
   logic   i_m_ready;
   count_t o_pkt_count;
   count_t o_err_count;

   beat_q_t     tx_beats;   // beats waiting at the user source
   word_q_t     exp_link;   // expected link words, in order
   word_q_t     flip_q;     // per link word xor mask, zero for clean words
   word_q_t     wire_q;     // words in flight on the modelled link
   beat_q_t     scoreboard; // expected user output beats
   logic [31:0] gen_state;

   tlast_link #(.CHECKSUM_EN(CHECKSUM_EN), .FIFO_DEPTH(FIFO_DEPTH)) u_tlast_link (
      .clk(clk), .i_rst(i_rst),
      .i_s_beat(i_s_beat), .i_s_valid(i_s_valid), .o_s_ready(o_s_ready),
      .o_link_data(o_link_data), .o_link_valid(o_link_valid), .i_link_ready(i_link_ready),
      .i_link_data(i_link_data), .i_link_valid(i_link_valid), .o_link_ready(o_link_ready),
      .o_m_beat(o_m_beat), .o_m_valid(o_m_valid), .i_m_ready(i_m_ready),
      .o_pkt_count(o_pkt_count), .o_err_count(o_err_count)
   );

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s ^ (s << 13);
      x = x ^ (x >> 17);
      return x ^ (x << 5);
   endfunction

   // link words of one packet, built from the encoding rules
   function automatic word_q_t encode_packet(input beat_q_t pkt);
      word_q_t words;
      csum_t   sum;
      sum = '0;
      foreach (pkt[i]) begin
         if (pkt[i].last || pkt[i].data == ESC_WORD) begin
            words.push_back(ESC_WORD);
            // last marker carries the fold, escaped data gets the zero marker
            words.push_back(pkt[i].last ? {(CHECKSUM_EN ? sum : 32'h0), 32'h1} : 64'h0);
         end
         words.push_back(pkt[i].data);
         if (!pkt[i].last) sum = sum ^ pkt[i].data[63:32] ^ pkt[i].data[31:0];
      end
      return words;
   endfunction

   task automatic fail_now(input string why);
      $display("%s", why);
      $display("Verification failed");
      $fatal(1);
   endtask

   task automatic check_word(input word_t got, input word_t exp, input string what);
      if (got !== exp)
         fail_now($sformatf("[ERROR] %0t: %s got %h expected %h", $time, what, got, exp));
   endtask

   task automatic check_beat(input beat_t got, input beat_t exp, input string what);
      if (got !== exp)
         fail_now($sformatf("[ERROR] %0t: %s got %h last %0b expected %h last %0b",
                            $time, what, got.data, got.last, exp.data, exp.last));
   endtask

   task automatic check_count(input count_t got, input count_t exp, input string what);
      if (got !== exp)
         fail_now($sformatf("[ERROR] %0t: %s got %0d expected %0d", $time, what, got, exp));
   endtask

   // queue one packet at the source, on the link and at the scoreboard
   task automatic send_packet(input int len, input bit corrupt, input bit esc_ends);
      beat_q_t pkt;
      word_q_t words;
      word_t   mask;
      beat_t   b;
      gen_state = xorshift(gen_state);
      mask      = corrupt ? (64'h1 << gen_state[10:5]) : 64'h0; // one bit only
      for (int i = 0; i < len; i++) begin
         gen_state = xorshift(gen_state);
         b.data    = {gen_state, xorshift(gen_state)};
         if (gen_state[2:0] == 3'd0 || (esc_ends && (i == 0 || i == len - 1)))
            b.data = ESC_WORD;
         // hit word stays plain data before and after the flip
         if (corrupt && i == 0 && (b.data == ESC_WORD || (b.data ^ mask) == ESC_WORD))
            b.data = ~b.data;
         b.last = (i == len - 1);
         pkt.push_back(b);
      end
      words = encode_packet(pkt);
      foreach (words[i]) begin
         exp_link.push_back(words[i]);
         flip_q.push_back(i == 0 ? mask : 64'h0);
      end
      foreach (pkt[i]) begin
         tx_beats.push_back(pkt[i]);
         b = pkt[i];
         if (i == 0) b.data = b.data ^ mask; // extractor passes the damaged word on
         scoreboard.push_back(b);
      end
   endtask

   // all queues empty, then one more edge for the counters
   task automatic drain(input string what);
      int n;
      n = 0;
      while (tx_beats.size() + exp_link.size() + wire_q.size() + scoreboard.size() != 0) begin
         @(posedge clk);
         n++;
         if (n > DRAIN_LIMIT) fail_now({"timeout, words still in flight after ", what});
      end
      @(negedge clk);
   endtask

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // user source, random valid gaps
   initial begin
      logic [31:0] rs;
      logic        sent;
      rs        = SEED ^ 32'h0000_0011;
      i_s_beat  = '0;
      i_s_valid = 1'b0;
      forever begin
         @(negedge clk);
         sent = i_s_valid && o_s_ready; // beat leaves on the coming edge
         @(posedge clk);
         #1;
         if (sent) void'(tx_beats.pop_front());
         if (sent || !i_s_valid) begin
            rs        = xorshift(rs);
            i_s_valid = (tx_beats.size() != 0) && (rs[1:0] != 2'b00);
            if (i_s_valid) i_s_beat = tx_beats[0];
         end
      end
   end

   // link model, loops link out back to link in with its own stalls
   initial begin
      logic [31:0] rl;
      logic        out_x;
      logic        in_x;
      rl           = SEED ^ 32'h0000_0022;
      i_link_ready = 1'b0;
      i_link_valid = 1'b0;
      i_link_data  = '0;
      forever begin
         @(negedge clk);
         out_x = o_link_valid && i_link_ready;
         in_x  = i_link_valid && o_link_ready;
         if (out_x) begin
            if (exp_link.size() == 0) fail_now("link carried a word that no packet produced");
            check_word(o_link_data, exp_link.pop_front(), "link word");
            wire_q.push_back(o_link_data ^ flip_q.pop_front()); // bit flip if armed
         end
         @(posedge clk);
         #1;
         if (in_x) void'(wire_q.pop_front());
         rl = xorshift(rl);
         if (in_x || !i_link_valid) begin
            i_link_valid = (wire_q.size() != 0) && (rl[2:0] != 3'd0);
            if (i_link_valid) i_link_data = wire_q[0];
         end
         i_link_ready = (rl[5:4] != 2'b00); // stall about one cycle in four
      end
   end

   // compares user output beats with the scoreboard
   initial begin
      logic [31:0] rm;
      rm        = SEED ^ 32'h0000_0033;
      i_m_ready = 1'b0;
      forever begin
         @(negedge clk);
         if (o_m_valid && i_m_ready) begin
            if (scoreboard.size() == 0) fail_now("output beat arrived with nothing expected");
            check_beat(o_m_beat, scoreboard.pop_front(), "output beat");
         end
         @(posedge clk);
         #1;
         rm        = xorshift(rm);
         i_m_ready = (rm[1:0] != 2'b00);
      end
   end

   initial begin
      int n_pkt;
      int n_err;
      gen_state = SEED;
      i_rst     = 1'b1;
      repeat (10) @(posedge clk);
      #1;
      i_rst = 1'b0;
      send_packet(3, 1'b0, 1'b1); // escape value mid-packet and as last beat
      send_packet(1, 1'b0, 1'b1); // single escape-valued last beat
      for (int p = 0; p < 28; p++) begin
         gen_state = xorshift(gen_state);
         send_packet(1 + int'(gen_state % 6), 1'b0, 1'b0);
      end
      drain("clean packets");
      n_pkt = 30;
      n_err = 0;
      check_count(o_pkt_count, count_t'(n_pkt), "packet count");
      check_count(o_err_count, count_t'(n_err), "error count");
      // one at a time so each error lands on its own packet
      for (int p = 0; p < 6; p++) begin
         gen_state = xorshift(gen_state);
         send_packet(2 + int'(gen_state % 5), (p % 2 == 0), 1'b0);
         drain("single packet");
         n_pkt++;
         if (p % 2 == 0) n_err++;
         check_count(o_pkt_count, count_t'(n_pkt), "packet count");
         check_count(o_err_count, count_t'(n_err), "error count");
      end
      $display("Verification passed");
      $finish;
   end

endmodule

`default_nettype wire

/* files.f */
tlast_pkg.sv
frame_checksum.sv
tlast_embed.sv
link_fifo.sv
tlast_extract.sv
link_stats.sv
tlast_link.sv
tb_tlast_link.sv

/* Bender.yml */
package:
  name: tlast_link

sources:
  - tlast_pkg.sv
  - frame_checksum.sv
  - tlast_embed.sv
  - link_fifo.sv
  - tlast_extract.sv
  - link_stats.sv
  - tlast_link.sv
  - target: simulation
    files:
      - tb_tlast_link.sv
